// ==== tb.f ====
src/encoderPkg.sv
src/frameGate.sv
src/stageDispatch.sv
src/subframeCounter.sv
src/encoderControl.sv
src/encoderSequencer.sv
verif/stageResponder.sv
verif/tbEncoderSequencer.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the encoder sequencer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module tbEncoderSequencer \
	-f tb.f \
	-o simEncoder

./obj_dir/simEncoder 2>&1 | tee sim.log

if grep -q "Finished with no errors" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== verif/tbEncoderSequencer.sv ====
`timescale 1ns/1ps

module tbEncoderSequencer
	import encoderPkg::*;
();

	localparam int frameLength = 80;
	localparam int subframeLength = 40;
	localparam int seedValue = 32'h9e08d52d;
	localparam int launchesPerFrame = 19 + 5 * (frameLength / subframeLength);
	localparam int worstStep = 14;	// Overhead plus slowest block
	localparam int cycleLimit = 100 + 3 * (launchesPerFrame * worstStep + 80);
	localparam int pulseStart = 0;
	localparam int pulseFrame = 1;
	localparam int pulseDivErr = 2;

	logic clock;
	logic reset;
	logic start;
	logic divErr;
	logic frameDone;
	stageVector stageDone;
	stageVector stageReady;
	mathSel mathSelect;
	regControl regCtrl;
	logic done;

	int cycleCount = 0;
	int launchCount = 0;
	int doneCount = 0;
	int topCount = 0;
	int t0Count = 0;
	int framePulses = 0;
	int triggerCycle = -1;	// Cycle of the expected autocorr strobe
	int topCycle = -1;
	int t0Cycle = -1;
	int doneCycle = -1;
	int errorCount = 0;
	logic seqIdle = 1'b1;
	logic waitingFrames = 1'b0;
	logic running = 1'b0;
	logic busyTb = 1'b0;
	stageId busyStage = autocorr;

	encoderSequencer #(
		.frameLength (frameLength),
		.subframeLength (subframeLength)
	) u_dut
	(
		.clock (clock),
		.reset (reset),
		.start (start),
		.divErr (divErr),
		.frameDone (frameDone),
		.stageDone (stageDone),
		.stageReady (stageReady),
		.mathSelect (mathSelect),
		.regCtrl (regCtrl),
		.done (done)
	);

	stageResponder #(
		.randomSeed (seedValue)
	) u_stageResponder
	(
		.clock (clock),
		.reset (reset),
		.stageReady (stageReady),
		.stageDone (stageDone)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// Reference model and checks
	//////////////////////////////////////////////////

	function automatic int expectedCode(input int launchNumber);
		return (launchNumber < 19) ? launchNumber : 19 + (launchNumber - 19) % 5;
	endfunction

	function automatic stageId expectedStage(input int launchNumber);
		case (expectedCode(launchNumber))
			0: return autocorr;
			1: return lag;
			2: return levinson;
			3: return az;
			4: return quaLsp;
			5: return intLpc;
			6: return intQlpc;
			7: return math1;
			8: return percVar;
			9, 10, 13, 14, 19, 20: return weightAz;
			11, 15: return residu;
			12, 16, 22, 23: return synFilt;
			17: return pitchOl;
			18: return math2;
			default: return math3;	// Code 21
		endcase
	endfunction

	// MSB of the vector is the first block
	function automatic stageId readyStage(input stageVector v);
		logic [stageCount-1:0] bits;
		stageId s;
		bits = v;
		s = autocorr;
		for (int i = 0; i < stageCount; i++)
			if (bits[stageCount - 1 - i])
				s = stageId'(i);
		return s;
	endfunction

	task automatic failRun(input string what);
		errorCount++;
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkStage(input string name, input stageId got, input stageId exp);
		if (got !== exp)
			failRun($sformatf("ERR t=%0t %s got %s expected %s", $time, name, got.name(),
				exp.name()));
	endtask

	task automatic checkMath(input string name, input mathSel got, input mathSel exp);
		if (got !== exp)
			failRun($sformatf("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	task automatic checkRegs(input string name, input regControl got, input regControl exp);
		if (got !== exp)
			failRun($sformatf("ERR t=%0t %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		if (got != exp)
			failRun($sformatf("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
			failRun($sformatf("ERR t=%0t %s got %b expected %b", $time, name, got, exp));
	endtask

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
			failRun($sformatf("Timeout: the test sequence did not finish in %0d cycles",
				cycleLimit));
	end

	// Outputs are stable at the falling edge
	always @(negedge clock)
	begin
		logic [stageCount-1:0] readyBits;
		logic [stageCount-1:0] doneBits;
		regControl expRegs;
		readyBits = stageReady;
		doneBits = stageDone;
		if (!reset)
		begin
			expRegs = '0;
			expRegs.tOpLoad = cycleCount == topCycle;
			expRegs.t0RangeLoad = cycleCount == t0Cycle;
			expRegs.addrLoad = cycleCount == t0Cycle;
			expRegs.clearRegs = seqIdle;
			checkRegs("regCtrl", regCtrl, expRegs);
			checkBit("done", done, cycleCount == doneCycle);
			if (running && launchCount == 0)
				checkBit("frameReady", u_dut.frameReady, cycleCount == triggerCycle - 2);
			if (readyBits != '0)
			begin
				if (!running)
					failRun("A ready strobe arrived while no frame was being processed");
				if (busyTb)
					failRun("A ready strobe arrived before the running block gave its done pulse");
				checkCount("stageReady bits set", $countones(readyBits), 1);
				if (launchCount == 0)
					checkCount("first ready cycle", cycleCount, triggerCycle);
				busyStage = readyStage(stageReady);
				checkStage("stageReady", busyStage, expectedStage(launchCount));
				checkMath("mathSelect", mathSelect, mathSel'(expectedCode(launchCount)));
				busyTb = 1'b1;
				launchCount++;
			end
			if (regCtrl.tOpLoad)
				topCount++;
			if (regCtrl.t0RangeLoad)
				t0Count++;

			if (divErr)
			begin
				running = 1'b0;	// Late done pulses are ignored after an abort
				busyTb = 1'b0;
				seqIdle = 1'b1;
			end
			else if (busyTb && doneBits[stageCount - 1 - int'(busyStage)])
			begin
				busyTb = 1'b0;
				if (busyStage == pitchOl)
					topCycle = cycleCount + 1;
				if (busyStage == math2)
					t0Cycle = cycleCount + 1;
				if (launchCount == launchesPerFrame)
					doneCycle = cycleCount + 3;	// stepDone, loopCheck, finish
			end
			if (done)
			begin
				doneCount++;
				running = 1'b0;
				seqIdle = 1'b1;
			end

			if (frameDone && waitingFrames)
			begin
				framePulses++;
				if (framePulses == framesPerTrigger)
				begin
					triggerCycle = cycleCount + 4;	// Capture, gate, launch, strobe
					running = 1'b1;
					waitingFrames = 1'b0;
				end
			end
			if (start)
			begin
				seqIdle = 1'b0;
				waitingFrames = 1'b1;
				framePulses = 0;
				launchCount = 0;
				topCount = 0;
				t0Count = 0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic pulseInput(input int which);
		@(posedge clock);
		case (which)
			pulseStart: start <= 1'b1;
			pulseFrame: frameDone <= 1'b1;
			default: divErr <= 1'b1;
		endcase
		@(posedge clock);
		start <= 1'b0;
		frameDone <= 1'b0;
		divErr <= 1'b0;
	endtask

	task automatic triggerFrame();
		pulseInput(pulseStart);
		repeat (4) @(posedge clock);
		pulseInput(pulseFrame);
		repeat (6) @(posedge clock);	// One frame pulse alone must not start the run
		pulseInput(pulseFrame);
	endtask

	task automatic checkFrameCounts(input int doneTotal);
		checkCount("ready pulses in frame", launchCount, launchesPerFrame);
		checkCount("done pulses", doneCount, doneTotal);
		checkCount("tOpLoad pulses", topCount, 1);
		checkCount("t0RangeLoad pulses", t0Count, 1);
	endtask

	initial
	begin
		reset = 1'b1;
		start = 1'b0;
		divErr = 1'b0;
		frameDone = 1'b0;
		repeat (8) @(posedge clock);
		reset <= 1'b0;

		repeat (20) @(posedge clock);	// Quiet with no start
		checkCount("ready pulses while idle", launchCount, 0);
		checkCount("done pulses while idle", doneCount, 0);

		triggerFrame();
		while (doneCount < 1)
			@(posedge clock);
		checkFrameCounts(1);

		// Division error in mid frame
		triggerFrame();
		while (launchCount < 10)
			@(posedge clock);
		pulseInput(pulseDivErr);
		repeat (40) @(posedge clock);
		checkCount("ready pulses after divErr", launchCount, 10);
		checkCount("done pulses after divErr", doneCount, 1);

		triggerFrame();
		while (doneCount < 2)
			@(posedge clock);
		checkFrameCounts(2);
		repeat (5) @(posedge clock);

		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== verif/stageResponder.sv ====
`timescale 1ns/1ps

module stageResponder
	import encoderPkg::*;
#(
	parameter int randomSeed = 1
)
(
	input logic clock,
	input logic reset,
	input stageVector stageReady,
	output stageVector stageDone
);

	int seed = randomSeed;
	logic pending = 1'b0;	// A block is working
	logic [2:0] waitCount = '0;
	logic [stageCount-1:0] pendingBit = '0;
	stageVector doneReg = '0;

	assign stageDone = doneReg;

	//////////////////////////////////////////////////
	// Block latency model
	//////////////////////////////////////////////////

	always @(posedge clock)
	begin
		logic [31:0] draw;
		logic [stageCount-1:0] readyBits;
		logic [stageCount-1:0] doneBits;
		logic [stageCount-1:0] extraBit;
		draw = $random(seed);
		readyBits = stageReady;
		doneBits = '0;
		extraBit = stageCount'(1) << draw[7:4];	// Zero when the draw is 15
		if (reset)
		begin
			pending <= 1'b0;
			waitCount <= '0;
		end
		else if (readyBits != '0)
		begin
			pending <= 1'b1;
			pendingBit <= readyBits;
			waitCount <= draw[2:0];	// Done 1 to 8 cycles after the strobe is seen
		end
		else if (pending)
		begin
			if (waitCount == 3'd0)
			begin
				doneBits = pendingBit;
				pending <= 1'b0;
			end
			else
				waitCount <= waitCount - 3'd1;
		end

		// Now and then a stray done on a block that is not running
		if (!reset && (pending || readyBits != '0) && doneBits == '0 && draw[10:8] == 3'd0
			&& (extraBit & (pendingBit | readyBits)) == '0)
			doneBits = extraBit;
		doneReg <= stageVector'(doneBits);
	end

endmodule

// ==== src/encoderSequencer.sv ====
`timescale 1ns/1ps

module encoderSequencer
	import encoderPkg::*;
#(
	parameter int unsigned frameLength = 80,
	parameter int unsigned subframeLength = 40
)
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic divErr,
	input logic frameDone,
	input stageVector stageDone,
	output stageVector stageReady,
	output mathSel mathSelect,
	output regControl regCtrl,
	output logic done
);

	logic frameReady;
	logic launch;
	logic abort;
	stageId launchStage;
	logic stepDone;
	logic clearIndex;
	logic stepIndex;
	logic lastSubframe;

	frameGate u_frameGate
	(
		.clock (clock),
		.reset (reset),
		.start (start),
		.frameDone (frameDone),
		.frameReady (frameReady)
	);

	encoderControl u_encoderControl
	(
		.clock (clock),
		.reset (reset),
		.start (start),
		.divErr (divErr),
		.frameReady (frameReady),
		.stepDone (stepDone),
		.lastSubframe (lastSubframe),
		.launch (launch),
		.abort (abort),
		.clearIndex (clearIndex),
		.stepIndex (stepIndex),
		.done (done),
		.launchStage (launchStage),
		.mathSelect (mathSelect),
		.regCtrl (regCtrl)
	);

	stageDispatch u_stageDispatch
	(
		.clock (clock),
		.reset (reset),
		.launch (launch),
		.abort (abort),
		.launchStage (launchStage),
		.stageDone (stageDone),
		.stageReady (stageReady),
		.stepDone (stepDone)
	);

	subframeCounter #(
		.frameLength (frameLength),
		.subframeLength (subframeLength)
	) u_subframeCounter
	(
		.clock (clock),
		.reset (reset),
		.clearIndex (clearIndex),
		.stepIndex (stepIndex),
		.lastSubframe (lastSubframe),
		.index ()	// Offset only needed for the loop test here
	);

endmodule

// ==== src/encoderControl.sv ====
`timescale 1ns/1ps

module encoderControl
	import encoderPkg::*;
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic divErr,
	input logic frameReady,
	input logic stepDone,
	input logic lastSubframe,
	output logic launch,
	output logic abort,
	output logic clearIndex,
	output logic stepIndex,
	output logic done,
	output stageId launchStage,
	output mathSel mathSelect,
	output regControl regCtrl
);

	controlState state;
	controlState nextState;
	encoderStep currentStep;
	encoderStep nextStep;
	logic stepEnd;

	// Block that serves each step
	function automatic stageId stepStage(input encoderStep step);
		case (step)
			stepAutocorr: return autocorr;
			stepLag: return lag;
			stepLevinson: return levinson;
			stepAz: return az;
			stepQuaLsp: return quaLsp;
			stepIntLpc: return intLpc;
			stepIntQlpc: return intQlpc;
			stepMath1: return math1;
			stepPercVar: return percVar;
			stepWeightAz1, stepWeightAz2, stepWeightAz3,
			stepWeightAz4, stepWeightAz5, stepWeightAz6: return weightAz;
			stepResidu1, stepResidu2: return residu;
			stepSynFilt1, stepSynFilt2, stepSynFilt3, stepSynFilt4: return synFilt;
			stepPitchOl: return pitchOl;
			stepMath2: return math2;
			stepMath3: return math3;
			default: return autocorr;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Step sequencing
	//////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		nextStep = currentStep;
		case (state)
			sIdle:
				if (start)
					nextState = sWaitFrame;
			sWaitFrame:
				if (frameReady)
				begin
					nextStep = stepAutocorr;
					nextState = sLaunch;
				end
			sLaunch:
				nextState = sBusy;
			sBusy:
				if (stepDone)
				begin
					if (currentStep == stepSynFilt4)
						nextState = sLoopCheck;	// End of a subframe
					else
					begin
						nextStep = encoderStep'(currentStep + 1'b1);
						nextState = sLaunch;
					end
				end
			sLoopCheck:
				if (lastSubframe)
					nextState = sFinish;
				else
				begin
					nextStep = stepWeightAz5;	// Back to top of subframe loop
					nextState = sLaunch;
				end
			sFinish:
				nextState = sIdle;
			default:
				nextState = sIdle;
		endcase
		if (divErr)
			nextState = sIdle;	// Abort from anywhere
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= sIdle;
			currentStep <= stepAutocorr;
		end
		else
		begin
			state <= nextState;
			currentStep <= nextStep;
		end
	end

	//////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////

	assign stepEnd = (state == sBusy) && stepDone;

	assign launch = state == sLaunch;
	assign abort = divErr;
	assign clearIndex = (state == sIdle) || divErr;
	assign stepIndex = (state == sLoopCheck) && !lastSubframe;
	assign done = state == sFinish;
	assign launchStage = stepStage(currentStep);
	assign mathSelect = mathSel'(currentStep);	// Held until next launch

	always_comb
	begin
		regCtrl = '0;
		regCtrl.tOpLoad = stepEnd && (currentStep == stepPitchOl);
		regCtrl.t0RangeLoad = stepEnd && (currentStep == stepMath2);
		regCtrl.addrLoad = stepEnd && (currentStep == stepMath2);
		regCtrl.clearRegs = state == sIdle;
	end

endmodule

// ==== src/subframeCounter.sv ====
`timescale 1ns/1ps

module subframeCounter
	import encoderPkg::*;
#(
	parameter int unsigned frameLength = 80,
	parameter int unsigned subframeLength = 40
)
(
	input logic clock,
	input logic reset,
	input logic clearIndex,
	input logic stepIndex,
	output logic lastSubframe,
	output subframeIndex index
);

	// Sample offset of the running subframe
	always_ff @(posedge clock)
	begin
		if (reset || clearIndex)
			index <= '0;
		else if (stepIndex)
			index <= index + subframeIndex'(subframeLength);
	end

	// Next step would run past the frame
	assign lastSubframe = (32'(index) + subframeLength) >= frameLength;

endmodule

// ==== src/stageDispatch.sv ====
`timescale 1ns/1ps

module stageDispatch
	import encoderPkg::*;
(
	input logic clock,
	input logic reset,
	input logic launch,
	input logic abort,
	input stageId launchStage,
	input stageVector stageDone,
	output stageVector stageReady,
	output logic stepDone
);

	logic busy;
	stageId busyStage;
	logic busyDone;

	// Only the busy block's done counts
	assign busyDone = busy && ((stageDone & stageMask(busyStage)) != '0);

	//////////////////////////////////////////////////
	// Ready strobe and busy tracking
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset || abort)
		begin
			busy <= 1'b0;
			stageReady <= '0;
			stepDone <= 1'b0;
		end
		else
		begin
			stageReady <= launch ? stageMask(launchStage) : '0;	// One-cycle strobe
			stepDone <= busyDone;
			if (launch)
				busy <= 1'b1;
			else if (busyDone)
				busy <= 1'b0;
		end
	end

	// Which block is running
	always_ff @(posedge clock)
	begin
		if (launch)
			busyStage <= launchStage;
	end

endmodule

// ==== src/frameGate.sv ====
`timescale 1ns/1ps

module frameGate
	import encoderPkg::*;
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic frameDone,
	output logic frameReady
);

	localparam int countWidth = $clog2(framesPerTrigger);

	logic armed;
	logic frameDoneQ;	// Registered frame pulse
	logic [countWidth-1:0] frameCount;
	logic countWrap;

	// Second pulse of the pair closes the count
	assign countWrap = armed && frameDoneQ && (frameCount == countWidth'(framesPerTrigger - 1));

	//////////////////////////////////////////////////
	// Arming and pulse capture
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			armed <= 1'b0;
			frameDoneQ <= 1'b0;
		end
		else
		begin
			if (start)
				armed <= 1'b1;	// Stays armed until reset
			frameDoneQ <= frameDone;
		end
	end

	//////////////////////////////////////////////////
	// Pulse counter and trigger
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			frameCount <= '0;
			frameReady <= 1'b0;
		end
		else
		begin
			frameReady <= countWrap;
			if (countWrap)
				frameCount <= '0;
			else if (armed && frameDoneQ)
				frameCount <= frameCount + 1'b1;
		end
	end

endmodule

// ==== src/encoderPkg.sv ====
package encoderPkg;

	localparam int stageCount = 15;
	localparam int framesPerTrigger = 2;	// Frame-done pulses per frame-ready

	// Processing blocks of the encoder
	typedef enum logic [3:0]
	{
		autocorr,
		lag,
		levinson,
		az,
		quaLsp,
		intLpc,
		intQlpc,
		math1,
		percVar,
		weightAz,
		residu,
		synFilt,
		pitchOl,
		math2,
		math3
	} stageId;

	// One bit per block, autocorr in the MSB
	typedef struct packed
	{
		logic autocorr;
		logic lag;
		logic levinson;
		logic az;
		logic quaLsp;
		logic intLpc;
		logic intQlpc;
		logic math1;
		logic percVar;
		logic weightAz;
		logic residu;
		logic synFilt;
		logic pitchOl;
		logic math2;
		logic math3;
	} stageVector;

	// Step value doubles as the math-select code
	typedef enum logic [4:0]
	{
		stepAutocorr, stepLag, stepLevinson, stepAz, stepQuaLsp,
		stepIntLpc, stepIntQlpc, stepMath1, stepPercVar,
		stepWeightAz1, stepWeightAz2, stepResidu1, stepSynFilt1,
		stepWeightAz3, stepWeightAz4, stepResidu2, stepSynFilt2,
		stepPitchOl, stepMath2,
		stepWeightAz5, stepWeightAz6, stepMath3, stepSynFilt3, stepSynFilt4
	} encoderStep;

	typedef logic [5:0] mathSel;
	typedef logic [15:0] subframeIndex;

	typedef enum logic [2:0]
	{
		sIdle,
		sWaitFrame,
		sLaunch,
		sBusy,
		sLoopCheck,
		sFinish
	} controlState;

	typedef struct packed
	{
		logic tOpLoad;	// Open-loop pitch lag
		logic t0RangeLoad;	// T0 min/max search range
		logic addrLoad;	// A and Aq coefficient addresses
		logic clearRegs;
	} regControl;

	// One-hot vector for a single block
	function automatic stageVector stageMask(input stageId s);
		logic [stageCount-1:0] mask;
		mask = '0;
		mask[stageCount - 1 - int'(s)] = 1'b1;
		return stageVector'(mask);
	endfunction

endpackage
